//--- Makefile
VERILATOR ?= verilator
FILELIST ?= filelist.f
TB_TOP ?= fragmentPipelineTb
RTL_TOP ?= fragmentPipeline
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
+incdir+hdl
hdl/rasterPkg.sv
hdl/colorMixer.sv
hdl/pipeDelay.sv
hdl/texEnvUnit.sv
hdl/framebufferBlender.sv
hdl/fragmentPipeline.sv
verification/fragmentPipelineTb.sv

//--- hdl/colorMixer.sv
/* Four-channel color mixer, a*b + c*d per channel with rounding and
   saturation, two clocks of latency */

`timescale 1ns/10ps

`include "raster_defs.svh"

module colorMixer
    import rasterPkg::*;
(
    input  logic   aclk,
    input  color_t colorA,
    input  color_t colorB,
    input  color_t colorC,
    input  color_t colorD,
    output color_t mixedColor
);

    localparam int chanWidth = `CHANNEL_WIDTH;
    localparam int prodWidth = 2 * chanWidth;
    localparam int sumWidth = prodWidth + 1;
    localparam channel_t chanMax = '1;

    logic [prodWidth-1:0] prodAB [4];
    logic [prodWidth-1:0] prodCD [4];
    logic [sumWidth-1:0] sum [4];
    channel_t mixedReg [4];

    // Stage one, channel 0 is red and channel 3 is alpha
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            prodAB[i] <= prodWidth'(colorA[i*chanWidth +: chanWidth])
                       * prodWidth'(colorB[i*chanWidth +: chanWidth]);
            prodCD[i] <= prodWidth'(colorC[i*chanWidth +: chanWidth])
                       * prodWidth'(colorD[i*chanWidth +: chanWidth]);
        end
    end

    // Adding M rounds so that x*M gives back x
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            sum[i] = sumWidth'(prodAB[i]) + sumWidth'(prodCD[i]) + sumWidth'(chanMax);
        end
    end

    // Stage two, top sum bit set means the shifted value exceeds M
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (sum[i][prodWidth])
                mixedReg[i] <= chanMax;
            else
                mixedReg[i] <= sum[i][prodWidth-1:chanWidth];
        end
    end

    assign mixedColor = {mixedReg[3], mixedReg[2], mixedReg[1], mixedReg[0]};

endmodule

//--- hdl/fragmentPipeline.sv
/* Fragment color stage top, texture environment then framebuffer blend,
   with the address, destination color and valid delayed alongside */

`timescale 1ns/10ps

`include "raster_defs.svh"

module fragmentPipeline
    import rasterPkg::*;
(
    input  logic         aclk,
    input  logic         arstN,
    input  logic         inValid,
    input  fragment_t    inFrag,
    input  texEnvMode_t  texMode,
    input  blendFactor_t srcFactor,
    input  blendFactor_t dstFactor,
    input  color_t       envColor,
    output logic         outValid,
    output pixelOut_t    outPixel
);

    pixelOut_t sideIn;
    pixelOut_t sideMid;
    logic validMid;
    color_t texColor;
    color_t blendedColor;
    fragAddr_t addrOut;

    // Destination color rides in the color field past the first unit
    assign sideIn = '{addr: inFrag.addr, color: inFrag.dest};

    texEnvUnit texEnv (
        .aclk     (aclk),
        .primary  (inFrag.primary),
        .texel    (inFrag.texel),
        .envColor (envColor),
        .mode     (texMode),
        .texColor (texColor)
    );

    pipeDelay #(.payload_t(pixelOut_t), .depth(`STAGE_DEPTH)) sideDelay (
        .aclk  (aclk),
        .arstN (arstN),
        .din   (sideIn),
        .dout  (sideMid)
    );

    pipeDelay #(.payload_t(logic), .depth(`STAGE_DEPTH)) validDelayTex (
        .aclk  (aclk),
        .arstN (arstN),
        .din   (inValid),
        .dout  (validMid)
    );

    framebufferBlender blender (
        .aclk         (aclk),
        .srcColor     (texColor),
        .dstColor     (sideMid.color),
        .srcFactor    (srcFactor),
        .dstFactor    (dstFactor),
        .blendedColor (blendedColor)
    );

    pipeDelay #(.payload_t(fragAddr_t), .depth(`STAGE_DEPTH)) addrDelay (
        .aclk  (aclk),
        .arstN (arstN),
        .din   (sideMid.addr),
        .dout  (addrOut)
    );

    pipeDelay #(.payload_t(logic), .depth(`STAGE_DEPTH)) validDelayBlend (
        .aclk  (aclk),
        .arstN (arstN),
        .din   (validMid),
        .dout  (outValid)
    );

    assign outPixel = '{addr: addrOut, color: blendedColor};

endmodule

//--- hdl/framebufferBlender.sv
/* Framebuffer blend, source times its factor plus destination times its
   factor through one color mixer, three clocks of latency */

`timescale 1ns/10ps

module framebufferBlender
    import rasterPkg::*;
(
    input  logic         aclk,
    input  color_t       srcColor,
    input  color_t       dstColor,
    input  blendFactor_t srcFactor,
    input  blendFactor_t dstFactor,
    output color_t       blendedColor
);

    mixOperands_t ops;
    mixOperands_t opsReg;

    // Factor enum to a four-channel factor color
    function automatic color_t expandFactor(
        input blendFactor_t factor,
        input channel_t     srcAlpha,
        input channel_t     dstAlpha
    );
        case (factor)
            blendZero:
                return '0;
            blendOne:
                return fillColor('1);
            blendSrcAlpha:
                return fillColor(srcAlpha);
            blendOneMinusSrcAlpha:
                return fillColor(~srcAlpha);
            blendDstAlpha:
                return fillColor(dstAlpha);
            blendOneMinusDstAlpha:
                return fillColor(~dstAlpha);
            default:
                return '0;
        endcase
    endfunction

    always_comb
    begin
        ops.a = srcColor;
        ops.b = expandFactor(srcFactor, srcColor.a, dstColor.a);
        ops.c = dstColor;
        ops.d = expandFactor(dstFactor, srcColor.a, dstColor.a);
    end

    // Operand stage ahead of the mixer
    always_ff @(posedge aclk)
    begin
        opsReg <= ops;
    end

    colorMixer mixer (
        .aclk       (aclk),
        .colorA     (opsReg.a),
        .colorB     (opsReg.b),
        .colorC     (opsReg.c),
        .colorD     (opsReg.d),
        .mixedColor (blendedColor)
    );

endmodule

//--- hdl/pipeDelay.sv
/* Register chain delaying any payload type by a fixed number of clocks */

`timescale 1ns/10ps

module pipeDelay #(
    parameter type payload_t = logic,
    parameter int depth = 1
) (
    input  logic     aclk,
    input  logic     arstN,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [depth];

    // Cleared chain keeps valid lines low after reset
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < depth; i++)
            begin
                stages[i] <= '0;
            end
        end
        else
        begin
            stages[0] <= din;
            for (int i = 1; i < depth; i++)
            begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[depth-1];

endmodule

//--- hdl/rasterPkg.sv
/* Color, fragment and pixel structs, texture environment and blend enums,
   and a helper that fills a color from one channel */

`include "raster_defs.svh"

package rasterPkg;

    typedef logic [`CHANNEL_WIDTH-1:0] channel_t;
    typedef logic [`ADDR_WIDTH-1:0] coord_t;

    // Alpha sits in the top channel
    typedef struct packed {
        channel_t a;
        channel_t b;
        channel_t g;
        channel_t r;
    } color_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } fragAddr_t;

    typedef struct packed {
        fragAddr_t addr;
        color_t primary;
        color_t texel;
        color_t dest;
    } fragment_t;

    typedef struct packed {
        fragAddr_t addr;
        color_t color;
    } pixelOut_t;

    // Four mixer operands, result is a*b + c*d
    typedef struct packed {
        color_t a;
        color_t b;
        color_t c;
        color_t d;
    } mixOperands_t;

    typedef enum logic [2:0] {
        texReplace,
        texModulate,
        texDecal,
        texAdd,
        texBlend
    } texEnvMode_t;

    typedef enum logic [2:0] {
        blendZero,
        blendOne,
        blendSrcAlpha,
        blendOneMinusSrcAlpha,
        blendDstAlpha,
        blendOneMinusDstAlpha
    } blendFactor_t;

    // Same channel value in all four channels
    function automatic color_t fillColor(input channel_t value);
        return '{a: value, b: value, g: value, r: value};
    endfunction

endpackage

//--- hdl/raster_defs.svh
/* Widths and pipeline depths shared by the fragment color stage */

`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Bits per color channel
`define CHANNEL_WIDTH 8

// Width of each pixel coordinate
`define ADDR_WIDTH 10

// Latency of the color mixer in clocks
`define MIXER_DEPTH 2

// Operand register plus mixer, per unit
`define STAGE_DEPTH (`MIXER_DEPTH + 1)

`endif

//--- hdl/texEnvUnit.sv
/* Texture environment, combines texel and primary color under the selected
   mode through one color mixer, three clocks of latency */

`timescale 1ns/10ps

module texEnvUnit
    import rasterPkg::*;
(
    input  logic        aclk,
    input  color_t      primary,
    input  color_t      texel,
    input  color_t      envColor,
    input  texEnvMode_t mode,
    output color_t      texColor
);

    mixOperands_t ops;
    mixOperands_t opsReg;

    // RGB first, then alpha overrides where the mode treats it apart
    always_comb
    begin
        ops = '0;
        case (mode)
            texReplace:
            begin
                ops.a = texel;
                ops.b = fillColor('1);
            end
            texModulate:
            begin
                ops.a = texel;
                ops.b = primary;
            end
            texDecal:
            begin
                ops.a = texel;
                ops.b = fillColor(texel.a);
                ops.c = primary;
                ops.d = fillColor(~texel.a);
                // Alpha keeps the primary
                ops.a.a = primary.a;
                ops.b.a = '1;
                ops.c.a = '0;
                ops.d.a = '0;
            end
            texAdd:
            begin
                ops.a = texel;
                ops.b = fillColor('1);
                ops.c = primary;
                ops.d = fillColor('1);
                // Alpha is modulated, not added
                ops.b.a = primary.a;
                ops.c.a = '0;
                ops.d.a = '0;
            end
            texBlend:
            begin
                ops.a = primary;
                ops.b = ~texel;
                ops.c = envColor;
                ops.d = texel;
                ops.a.a = texel.a;
                ops.b.a = primary.a;
                ops.c.a = '0;
                ops.d.a = '0;
            end
            default:
            begin
                ops = '0;
            end
        endcase
    end

    always_ff @(posedge aclk)
    begin
        opsReg <= ops;
    end

    colorMixer mixer (
        .aclk       (aclk),
        .colorA     (opsReg.a),
        .colorB     (opsReg.b),
        .colorC     (opsReg.c),
        .colorD     (opsReg.d),
        .mixedColor (texColor)
    );

endmodule

//--- verification/fragmentPipelineTb.sv
/* Testbench for the fragment color stage, with trace reader, driver,
   result checker and cycle limit */

`timescale 1ns/10ps

`include "raster_defs.svh"

module fragmentPipelineTb
    import rasterPkg::*;
();

    localparam int pipeLatency = 6;
    localparam int drainCycles = 7;
    localparam int unsigned lcgSeed = 27956;
    localparam int colorBits = 4 * `CHANNEL_WIDTH;

    typedef struct {
        logic         cfgChange;
        texEnvMode_t  mode;
        blendFactor_t srcFactor;
        blendFactor_t dstFactor;
        color_t       env;
        color_t       primary;
        color_t       texel;
        color_t       dest;
        color_t       expected;
    } traceEntry_t;

    // Drive cycle, address and color of one fragment in flight
    typedef struct packed {
        logic [31:0] cycle;
        fragAddr_t   addr;
        color_t      color;
    } pending_t;

    logic aclk = 1'b0;
    logic arstN;
    logic inValid;
    fragment_t inFrag;
    texEnvMode_t texMode;
    blendFactor_t srcFactor;
    blendFactor_t dstFactor;
    color_t envColor;
    logic outValid;
    pixelOut_t outPixel;

    traceEntry_t traceQ[$];
    pending_t pendingQ[$];
    pending_t front;
    int unsigned cycles = 0;
    int unsigned cycleLimit = 0;
    int unsigned lcgState = lcgSeed;

    fragmentPipeline DUT (
        .aclk      (aclk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inFrag    (inFrag),
        .texMode   (texMode),
        .srcFactor (srcFactor),
        .dstFactor (dstFactor),
        .envColor  (envColor),
        .outValid  (outValid),
        .outPixel  (outPixel)
    );

    always #50 aclk = ~aclk;

    function automatic int unsigned nextRandom(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected)
            stopWithError($sformatf("FAILED at %0t ns: %s expected %0h, got %0h",
                                    $time, what, expected, actual));
    endtask

    // One fragment per line and lines starting with # skipped
    task automatic readTrace();
        int fd;
        int count;
        int flag;
        int modeVal;
        int srcVal;
        int dstVal;
        string line;
        logic [colorBits-1:0] env;
        logic [colorBits-1:0] primary;
        logic [colorBits-1:0] texel;
        logic [colorBits-1:0] dest;
        logic [colorBits-1:0] expected;
        traceEntry_t entry;
        fd = $fopen("verification/fragmentTrace.txt", "r");
        if (fd == 0)
            stopWithError("Cannot open the trace file verification/fragmentTrace.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() >= 2 && line.substr(0, 0) != "#")
                begin
                    count = $sscanf(line, "%d %d %d %d %h %h %h %h %h", flag, modeVal,
                                    srcVal, dstVal, env, primary, texel, dest, expected);
                    if (count != 9)
                        stopWithError({"Malformed trace line: ", line});
                    else
                    begin
                        entry.cfgChange = (flag != 0);
                        entry.mode = texEnvMode_t'(modeVal[2:0]);
                        entry.srcFactor = blendFactor_t'(srcVal[2:0]);
                        entry.dstFactor = blendFactor_t'(dstVal[2:0]);
                        entry.env = color_t'(env);
                        entry.primary = color_t'(primary);
                        entry.texel = color_t'(texel);
                        entry.dest = color_t'(dest);
                        entry.expected = color_t'(expected);
                        traceQ.push_back(entry);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Drain the pipeline before configuration levels move
    task automatic driveFragment(input traceEntry_t entry);
        fragAddr_t addr;
        pending_t result;
        if (entry.cfgChange)
        begin
            inValid = 1'b0;
            repeat (drainCycles) @(negedge aclk);
            texMode = entry.mode;
            srcFactor = entry.srcFactor;
            dstFactor = entry.dstFactor;
            envColor = entry.env;
        end
        lcgState = nextRandom(lcgState);
        addr.x = lcgState[16 +: `ADDR_WIDTH];
        lcgState = nextRandom(lcgState);
        addr.y = lcgState[16 +: `ADDR_WIDTH];
        inFrag.addr = addr;
        inFrag.primary = entry.primary;
        inFrag.texel = entry.texel;
        inFrag.dest = entry.dest;
        inValid = 1'b1;
        // Cycle in which the fragment is presented
        result.cycle = cycles;
        result.addr = addr;
        result.color = entry.expected;
        pendingQ.push_back(result);
        @(negedge aclk);
    endtask

    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit)
            stopWithError($sformatf("Timeout after %0d cycles, %0d results still missing",
                                    cycles, pendingQ.size()));
    end

    // Registered outputs are settled by the falling edge
    always @(negedge aclk)
    begin
        if ($isunknown(outValid))
            stopWithError("Output valid is unknown");
        else if (outValid)
        begin
            if (pendingQ.size() == 0)
                stopWithError("Output valid seen with no fragment in flight");
            else
            begin
                front = pendingQ.pop_front();
                checkValue("latency", 64'(pipeLatency), 64'(cycles - front.cycle));
                checkValue("address", 64'(front.addr), 64'(outPixel.addr));
                checkValue("color", 64'(front.color), 64'(outPixel.color));
            end
        end
    end

    initial
    begin
        arstN = 1'b0;
        inValid = 1'b0;
        inFrag = '0;
        texMode = texReplace;
        srcFactor = blendOne;
        dstFactor = blendZero;
        envColor = '0;
        readTrace();
        cycleLimit = traceQ.size() * 8 + 50;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        arstN = 1'b1;
        @(negedge aclk);
        foreach (traceQ[i])
            driveFragment(traceQ[i]);
        inValid = 1'b0;
        while (pendingQ.size() != 0)
            @(negedge aclk);
        // Extra clocks catch any stray result
        repeat (drainCycles) @(negedge aclk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verification/fragmentTrace.txt
# flag mode srcFactor dstFactor envColor primary texel dest expected, colors hex with alpha on top
# flag 1 drains the pipeline first, modes 0..4 replace..blend, factors 0..5 zero..oneMinusDstAlpha
1 0 1 0 00000000 11223344 a5c3e10f 00000000 a5c3e10f
0 0 1 0 00000000 ffffffff 00ff7f80 12345678 00ff7f80
0 0 1 0 00000000 01020304 deadbeef 55555555 deadbeef
1 1 1 0 00000000 80808080 80808080 00000000 40404040
0 1 1 0 00000000 40ff20ff ff00ff40 00000000 40002040
0 1 1 0 00000000 0a141e28 c864321e 00000000 08080605
1 2 1 0 00000000 4010ff20 80ff0000 00000000 40887f10
0 2 1 0 00000000 99abcdef ff123456 00000000 99123456
0 2 1 0 00000000 7f112233 00aabbcc 00000000 7f112233
1 3 1 0 00000000 802040f0 80102030 00000000 403060ff
0 3 1 0 00000000 ff01fe00 ffff0100 00000000 ffffff00
1 4 1 0 ffff8000 ff00ffff 40ff8000 00000000 40ffbfff
0 4 1 0 ffff8000 80808080 ff0040c0 00000000 80808020
1 0 2 3 00000000 00000000 80ff0040 2000ff80 50807f60
0 0 2 3 00000000 00000000 ff112233 44556677 ff112233
1 0 4 5 00000000 00000000 008040ff 8000c010 40408088
0 0 4 5 00000000 00000000 aabbccdd 00123456 00123456
1 0 1 1 00000000 00000000 80901001 9080f001 ffffff02
